// ==== common/rv_decode_params.svh ====
// ==========================================================
// Global sizing for the decode stage
// XLEN selects RV32 (32) or RV64 (64)
// NUM_REGS stays at 32 since register indices are 5 bits
// ==========================================================
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// Integer data width, 32 or 64
`define XLEN 32

// Integer register count, x0 included
`define NUM_REGS 32

`endif

// ==== common/rv_decode_pkg.sv ====
// ==========================================================
// Shared types of the decode stage
// Widths follow the XLEN macro of the params header
// op_class_e is 5 bits wide since it holds 17 classes
// ==========================================================
`include "rv_decode_params.svh"

package rv_decode_pkg;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opc_load     = 7'b0000011,
    opc_load_fp  = 7'b0000111,
    opc_op_imm   = 7'b0010011,
    opc_auipc    = 7'b0010111,
    opc_store    = 7'b0100011,
    opc_store_fp = 7'b0100111,
    opc_amo      = 7'b0101111,
    opc_op       = 7'b0110011,
    opc_lui      = 7'b0110111,
    opc_op_32    = 7'b0111011,
    opc_madd     = 7'b1000011,
    opc_msub     = 7'b1000111,
    opc_nmsub    = 7'b1001011,
    opc_nmadd    = 7'b1001111,
    opc_op_fp    = 7'b1010011,
    opc_branch   = 7'b1100011,
    opc_jalr     = 7'b1100111,
    opc_jal      = 7'b1101111,
    opc_system   = 7'b1110011
  } opcode_e;

  // Decoded instruction class
  typedef enum logic [4:0] {
    op, op_imm, op_32, load, store, branch, jal, jalr, lui, auipc,
    system, amo, load_fp, store_fp, fma, op_fp, invalid
  } op_class_e;

  // Execute ALU operations
  typedef enum logic [3:0] {
    add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op, pass_b, mul_div
  } alu_op_e;

  // Raw register and function fields
  typedef struct packed {
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rs3;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] funct5;
  } inst_fields_t;

  // Extension and system flags
  typedef struct packed {
    logic        is_csr;
    logic        is_ecall;
    logic        is_ebreak;
    logic        is_mret;
    logic        is_sret;
    logic        is_sfence_vma;
    logic        is_mul_div;
    logic        is_word_op;
    logic        is_atomic;
    logic        aq;
    logic        rl;
    logic        is_fp;
    logic        fp_fmt;
    logic [11:0] csr_addr;
    logic [2:0]  fp_rm;
  } dec_flags_t;

  // Execute controls
  typedef struct packed {
    alu_op_e alu_op;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    jump;
    logic    illegal;
  } ctrl_t;

  // ID/EX pipeline payload
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    inst_fields_t     fields;
    dec_flags_t       flags;
    ctrl_t            ctrl;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
  } id_ex_t;

endpackage

// ==== rtl/decoder/decoder.sv ====
// ==========================================================
// Instruction field, class and immediate decode
// Purely combinational
// Class comes from instr[6:0] only; funct fields are not
// checked here, unknown opcodes map to the invalid class
// ==========================================================
`timescale 1ns/1ns
`include "rv_decode_params.svh"

module decoder (
  input  logic [31:0]                 instr,
  output rv_decode_pkg::inst_fields_t fields,
  output rv_decode_pkg::dec_flags_t   flags,
  output rv_decode_pkg::op_class_e    op_class,
  output logic [`XLEN-1:0]            imm
);

  localparam int XLEN = `XLEN;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic            is_system;
  logic            sys_f3_zero;

  // Field slices
  always_comb begin
    fields.rd     = instr[11:7];
    fields.rs1    = instr[19:15];
    fields.rs2    = instr[24:20];
    fields.rs3    = instr[31:27];
    fields.funct3 = instr[14:12];
    fields.funct7 = instr[31:25];
    // AMO op type
    fields.funct5 = instr[31:27];
  end

  // ========================================================
  // Opcode class
  // ========================================================
  always_comb begin
    case (instr[6:0])
      rv_decode_pkg::opc_op:       op_class = rv_decode_pkg::op;
      rv_decode_pkg::opc_op_imm:   op_class = rv_decode_pkg::op_imm;
      rv_decode_pkg::opc_op_32:    op_class = rv_decode_pkg::op_32;
      rv_decode_pkg::opc_load:     op_class = rv_decode_pkg::load;
      rv_decode_pkg::opc_store:    op_class = rv_decode_pkg::store;
      rv_decode_pkg::opc_branch:   op_class = rv_decode_pkg::branch;
      rv_decode_pkg::opc_jal:      op_class = rv_decode_pkg::jal;
      rv_decode_pkg::opc_jalr:     op_class = rv_decode_pkg::jalr;
      rv_decode_pkg::opc_lui:      op_class = rv_decode_pkg::lui;
      rv_decode_pkg::opc_auipc:    op_class = rv_decode_pkg::auipc;
      rv_decode_pkg::opc_system:   op_class = rv_decode_pkg::system;
      rv_decode_pkg::opc_amo:      op_class = rv_decode_pkg::amo;
      rv_decode_pkg::opc_load_fp:  op_class = rv_decode_pkg::load_fp;
      rv_decode_pkg::opc_store_fp: op_class = rv_decode_pkg::store_fp;
      // All four R4 opcodes share one class
      rv_decode_pkg::opc_madd,
      rv_decode_pkg::opc_msub,
      rv_decode_pkg::opc_nmsub,
      rv_decode_pkg::opc_nmadd:    op_class = rv_decode_pkg::fma;
      rv_decode_pkg::opc_op_fp:    op_class = rv_decode_pkg::op_fp;
      default:                     op_class = rv_decode_pkg::invalid;
    endcase
  end

  // ========================================================
  // System, M, A and F/D flags
  // ========================================================
  assign is_system   = (op_class == rv_decode_pkg::system);
  // Privileged forms have funct3 zero
  assign sys_f3_zero = is_system && (instr[14:12] == 3'b000);

  always_comb begin
    flags.is_csr        = is_system && (instr[14:12] != 3'b000);
    flags.is_ecall      = sys_f3_zero && (instr[31:20] == 12'h000);
    flags.is_ebreak     = sys_f3_zero && (instr[31:20] == 12'h001);
    flags.is_mret       = sys_f3_zero && (instr[31:20] == 12'h302);
    flags.is_sret       = sys_f3_zero && (instr[31:20] == 12'h102);
    // rs1 and rs2 carry vaddr and asid
    flags.is_sfence_vma = sys_f3_zero && (instr[31:25] == 7'b0001001);
    // MUL/DIV family on OP and OP-32
    flags.is_mul_div    = ((op_class == rv_decode_pkg::op) ||
                           (op_class == rv_decode_pkg::op_32)) &&
                          (instr[31:25] == 7'b0000001);
    flags.is_word_op    = (op_class == rv_decode_pkg::op_32);
    flags.is_atomic     = (op_class == rv_decode_pkg::amo);
    flags.aq            = instr[26];
    flags.rl            = instr[25];
    flags.is_fp         = (op_class == rv_decode_pkg::load_fp)  ||
                          (op_class == rv_decode_pkg::store_fp) ||
                          (op_class == rv_decode_pkg::fma)      ||
                          (op_class == rv_decode_pkg::op_fp);
    // Low fmt bit at instr[25] in R and R4 forms, 1 means double
    flags.fp_fmt        = instr[25];
    flags.csr_addr      = instr[31:20];
    // Rounding mode shares the funct3 slot
    flags.fp_rm         = instr[14:12];
  end

  // ========================================================
  // Immediates, sign-extended from their top bit
  // ========================================================
  assign imm_i = XLEN'($signed(instr[31:20]));
  assign imm_s = XLEN'($signed({instr[31:25], instr[11:7]}));
  // B and J are halfword aligned
  assign imm_b = XLEN'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
  assign imm_u = XLEN'($signed({instr[31:12], 12'b0}));
  assign imm_j = XLEN'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));

  // Format select per class
  always_comb begin
    case (op_class)
      rv_decode_pkg::op_imm,
      rv_decode_pkg::load,
      rv_decode_pkg::jalr,
      rv_decode_pkg::load_fp,
      rv_decode_pkg::system:   imm = imm_i;
      rv_decode_pkg::store,
      rv_decode_pkg::store_fp: imm = imm_s;
      rv_decode_pkg::branch:   imm = imm_b;
      rv_decode_pkg::lui,
      rv_decode_pkg::auipc:    imm = imm_u;
      rv_decode_pkg::jal:      imm = imm_j;
      // R-type, AMO, FP ops, invalid
      default:                 imm = '0;
    endcase
  end

endmodule

// ==== rtl/decoder/control_unit.sv ====
// ==========================================================
// Execute control generation from class and funct fields
// Combinational; FP classes get no integer controls
// OP-32 is flagged illegal when XLEN is 32
// ==========================================================
`timescale 1ns/1ns
`include "rv_decode_params.svh"

module control_unit (
  input  rv_decode_pkg::op_class_e    op_class,
  input  rv_decode_pkg::inst_fields_t fields,
  output rv_decode_pkg::ctrl_t        ctrl
);

  localparam int XLEN = `XLEN;

  // funct7[5] picks sub/sra
  logic                   alt;
  rv_decode_pkg::alu_op_e f3_op;

  assign alt = fields.funct7[5];

  // ALU op from funct3, shift-right kind from alt
  always_comb begin
    case (fields.funct3)
      3'b000:  f3_op = rv_decode_pkg::add;
      3'b001:  f3_op = rv_decode_pkg::sll;
      3'b010:  f3_op = rv_decode_pkg::slt;
      3'b011:  f3_op = rv_decode_pkg::sltu;
      3'b100:  f3_op = rv_decode_pkg::xor_op;
      3'b101:  f3_op = alt ? rv_decode_pkg::sra : rv_decode_pkg::srl;
      3'b110:  f3_op = rv_decode_pkg::or_op;
      default: f3_op = rv_decode_pkg::and_op;
    endcase
  end

  // ========================================================
  // Per-class controls
  // ========================================================
  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = rv_decode_pkg::add;
    case (op_class)
      rv_decode_pkg::op,
      rv_decode_pkg::op_32: begin
        if (fields.funct7 == 7'b0000001) begin
          ctrl.alu_op = rv_decode_pkg::mul_div;
        end else if (fields.funct3 == 3'b000 && alt) begin
          ctrl.alu_op = rv_decode_pkg::sub;
        end else begin
          ctrl.alu_op = f3_op;
        end
        ctrl.reg_write = 1'b1;
      end
      // No subi, only shifts look at funct7
      rv_decode_pkg::op_imm: begin
        ctrl.alu_op    = f3_op;
        ctrl.reg_write = 1'b1;
      end
      rv_decode_pkg::load: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
      end
      rv_decode_pkg::store: begin
        ctrl.mem_write = 1'b1;
      end
      // Read-modify-write, address via add
      rv_decode_pkg::amo: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      // Compare by subtraction
      rv_decode_pkg::branch: begin
        ctrl.alu_op = rv_decode_pkg::sub;
        ctrl.branch = 1'b1;
      end
      // Target via add, link to rd
      rv_decode_pkg::jal,
      rv_decode_pkg::jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
      end
      rv_decode_pkg::lui: begin
        ctrl.alu_op    = rv_decode_pkg::pass_b;
        ctrl.reg_write = 1'b1;
      end
      // pc + imm
      rv_decode_pkg::auipc: begin
        ctrl.reg_write = 1'b1;
      end
      // Only CSR forms return a value
      rv_decode_pkg::system: begin
        ctrl.reg_write = (fields.funct3 != 3'b000);
      end
      rv_decode_pkg::invalid: begin
        ctrl.illegal = 1'b1;
      end
      default: begin
        // FP classes, flagged only
        ctrl.illegal = 1'b0;
      end
    endcase
    // W-suffix ops need RV64
    if (op_class == rv_decode_pkg::op_32 && XLEN == 32) begin
      ctrl.illegal = 1'b1;
    end
  end

endmodule

// ==== rtl/regfile.sv ====
// ==========================================================
// Integer register file, 2 read ports, 1 write port
// Reads are combinational with write-through of wb_data
// x0 reads zero and ignores writes
// ==========================================================
`timescale 1ns/1ns
`include "rv_decode_params.svh"

module regfile (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  output logic [`XLEN-1:0] rs1_data,
  output logic [`XLEN-1:0] rs2_data,
  input  logic             wb_en,
  input  logic [4:0]       wb_rd,
  input  logic [`XLEN-1:0] wb_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // Write at the edge, x0 never written
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_rd != 5'd0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // One read port with bypass
  function automatic logic [`XLEN-1:0] read_port(input logic [4:0] idx);
    if (idx == 5'd0) begin
      return '0;
    end else if (wb_en && wb_rd == idx) begin
      return wb_data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

endmodule

// ==== rtl/decode_stage.sv ====
// ==========================================================
// Decode stage top with the ID/EX output register
// One item in flight, 1 cycle latency, valid/ready both sides
// Operands are sampled at accept, no hazard check done here
// ==========================================================
`timescale 1ns/1ns
`include "rv_decode_params.svh"

module decode_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  // Instruction in
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [31:0]           in_instr,
  input  logic [`XLEN-1:0]      in_pc,
  // ID/EX out
  output logic                  out_valid,
  input  logic                  out_ready,
  output rv_decode_pkg::id_ex_t out_payload,
  // Writeback port
  input  logic                  wb_en,
  input  logic [4:0]            wb_rd,
  input  logic [`XLEN-1:0]      wb_data
);

  rv_decode_pkg::inst_fields_t fields;
  rv_decode_pkg::dec_flags_t   flags;
  rv_decode_pkg::op_class_e    op_class;
  rv_decode_pkg::ctrl_t        ctrl;
  rv_decode_pkg::id_ex_t       payload_d;
  logic [`XLEN-1:0]            imm;
  logic [`XLEN-1:0]            rs1_data;
  logic [`XLEN-1:0]            rs2_data;
  logic                        accept;

  // ========================================================
  // Decode datapath
  // ========================================================
  decoder u_decoder (
    .instr    (in_instr),
    .fields   (fields),
    .flags    (flags),
    .op_class (op_class),
    .imm      (imm)
  );

  control_unit u_control_unit (
    .op_class (op_class),
    .fields   (fields),
    .ctrl     (ctrl)
  );

  regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (fields.rs1),
    .rs2      (fields.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  // Next payload
  always_comb begin
    payload_d.pc       = in_pc;
    payload_d.fields   = fields;
    payload_d.flags    = flags;
    payload_d.ctrl     = ctrl;
    payload_d.imm      = imm;
    payload_d.rs1_data = rs1_data;
    payload_d.rs2_data = rs2_data;
  end

  // ========================================================
  // ID/EX handshake
  // ========================================================
  // Free, or current item leaving this cycle
  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Held while stalled
  always_ff @(posedge clk) begin
    if (accept) begin
      out_payload <= payload_d;
    end
  end

endmodule

// ==== verification/clk_gen.sv ====
// ============================================================
// Testbench clock and reset source
// 10 ns period, reset low for the first 5 rising edges
// ============================================================
`timescale 1ns/1ns

module clk_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release just after the 5th edge
  initial begin
    arst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
  end

endmodule

// ==== verification/decode_stage_properties.sv ====
// ============================================================
// Concurrent checks bound into the decode stage
// Keeps its own shadow of the register file from the wb port
// Snapshots the accepted instruction, pc and operands
// ============================================================
`timescale 1ns/1ns
`include "rv_decode_params.svh"

module decode_stage_properties (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  in_valid,
  input logic                  in_ready,
  input logic [31:0]           in_instr,
  input logic [`XLEN-1:0]      in_pc,
  input logic                  out_valid,
  input logic                  out_ready,
  input rv_decode_pkg::id_ex_t out_payload,
  input logic                  wb_en,
  input logic [4:0]            wb_rd,
  input logic [`XLEN-1:0]      wb_data
);

  localparam int XLEN = `XLEN;

  int unsigned     fail_count = 0;
  logic [XLEN-1:0] shadow [`NUM_REGS];
  logic [31:0]     acc_instr;
  logic [XLEN-1:0] exp_pc;
  logic [XLEN-1:0] exp_rs1;
  logic [XLEN-1:0] exp_rs2;
  logic            accept;

  assign accept = in_valid && in_ready;

  // Immediate by major opcode from the ISA bit layout
  function automatic logic [XLEN-1:0] expected_imm(input logic [31:0] ins);
    logic [31:0] v;
    case (ins[6:0])
      // I-type loads, op-imm, jalr, fp load and system
      7'h03, 7'h07, 7'h13, 7'h67, 7'h73: v = {{20{ins[31]}}, ins[31:20]};
      7'h23, 7'h27: v = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      7'h63: v = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      7'h37, 7'h17: v = {ins[31:12], 12'h000};
      7'h6f: v = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      default: v = 32'h0;
    endcase
    return XLEN'($signed(v));
  endfunction

  // Architectural value seen by a read with its pending write
  function automatic logic [XLEN-1:0] operand_value(input logic [4:0] idx);
    return (idx == 5'd0) ? '0 : (wb_en && wb_rd == idx) ? wb_data : shadow[idx];
  endfunction

  // ==========================================================
  // Reference state
  // ==========================================================
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        shadow[i] <= '0;
      end
    end else if (wb_en && wb_rd != 5'd0) begin
      shadow[wb_rd] <= wb_data;
    end
  end

  // Snapshot at the accepting edge
  always @(posedge clk) begin
    if (accept) begin
      acc_instr <= in_instr;
      exp_pc    <= in_pc;
      exp_rs1   <= operand_value(in_instr[19:15]);
      exp_rs2   <= operand_value(in_instr[24:20]);
    end
  end

  // ==========================================================
  // Properties
  // ==========================================================
  reset_idle: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high during reset");
    end

  reset_exit: assert property (@(posedge clk) !arst_n |=> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high on the first edge after reset");
    end

  one_cycle_latency: assert property (@(posedge clk) disable iff (!arst_n)
    accept |=> out_valid)
    else begin
      fail_count++;
      $error("accepted item not valid one cycle later");
    end

  payload_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_payload))
    else begin
      fail_count++;
      $error("payload changed or dropped under back-pressure");
    end

  imm_format: assert property (@(posedge clk) disable iff (!arst_n)
    accept |=> out_payload.imm == expected_imm(acc_instr))
    else begin
      fail_count++;
      $error("immediate differs from its format rule");
    end

  operands: assert property (@(posedge clk) disable iff (!arst_n)
    accept |=> out_payload.rs1_data == exp_rs1 && out_payload.rs2_data == exp_rs2)
    else begin
      fail_count++;
      $error("operand differs from the shadow register file");
    end

  // pc and register fields pass straight through
  passthrough: assert property (@(posedge clk) disable iff (!arst_n)
    accept |=> out_payload.pc == exp_pc &&
               out_payload.fields.rd == acc_instr[11:7] &&
               out_payload.fields.rs1 == acc_instr[19:15] &&
               out_payload.fields.rs2 == acc_instr[24:20] &&
               out_payload.fields.funct3 == acc_instr[14:12] &&
               out_payload.fields.funct7 == acc_instr[31:25])
    else begin
      fail_count++;
      $error("pc or register fields differ from the accepted instruction");
    end

  // Integer loads, stores and AMOs touch memory, FP ones do not
  mem_branch_jump: assert property (@(posedge clk) disable iff (!arst_n)
    accept |=>
      out_payload.ctrl.mem_read == (acc_instr[6:0] inside {7'h03, 7'h2f}) &&
      out_payload.ctrl.mem_write == (acc_instr[6:0] inside {7'h23, 7'h2f}) &&
      out_payload.ctrl.branch == (acc_instr[6:0] == 7'h63) &&
      out_payload.ctrl.jump == (acc_instr[6:0] inside {7'h67, 7'h6f}))
    else begin
      fail_count++;
      $error("memory, branch or jump control differs from the opcode");
    end

  x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && out_payload.fields.rs1 == 5'd0 |-> out_payload.rs1_data == '0)
    else begin
      fail_count++;
      $error("x0 read returned nonzero");
    end

endmodule

bind decode_stage decode_stage_properties u_properties (
  .clk         (clk),
  .arst_n      (arst_n),
  .in_valid    (in_valid),
  .in_ready    (in_ready),
  .in_instr    (in_instr),
  .in_pc       (in_pc),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .out_payload (out_payload),
  .wb_en       (wb_en),
  .wb_rd       (wb_rd),
  .wb_data     (wb_data)
);

// ==== verification/tb_decode_stage.sv ====
// ============================================================
// Testbench for the decode stage
// Immediate asserts check classification, reset and counts,
// the bound property module checks operands, immediates,
// pc, register fields and memory controls
// ============================================================
`timescale 1ns/1ns
`include "rv_decode_params.svh"

module tb_decode_stage;

  localparam int XLEN        = `XLEN;
  localparam int RAND_ITEMS  = 200;
  // Cycle budget of each test
  localparam int RESET_LEN   = 10;
  localparam int CLASS_LEN   = 13 * 4;
  localparam int RANDOM_LEN  = RAND_ITEMS * 6;
  localparam int STALL_LEN   = 30;
  localparam int CYCLE_LIMIT = 2 * (RESET_LEN + CLASS_LEN + RANDOM_LEN + STALL_LEN);

  // ECALL EBREAK MRET SRET SFENCE.VMA CSRRW MUL DIVW AMOADD.W.aq FMADD.D SUB SRA bad-opcode
  localparam logic [31:0] FIXED [13] = '{
    32'h00000073, 32'h00100073, 32'h30200073, 32'h10200073, 32'h12208073,
    32'h300312f3, 32'h022081b3, 32'h0220c1bb, 32'h0420a1af, 32'h223100c3,
    32'h402081b3, 32'h4020d1b3, 32'h0000007f
  };
  // Every major opcode plus one unused
  localparam logic [6:0] OPCODES [20] = '{
    7'h03, 7'h07, 7'h13, 7'h17, 7'h23, 7'h27, 7'h2f, 7'h33, 7'h37, 7'h3b,
    7'h43, 7'h47, 7'h4b, 7'h4f, 7'h53, 7'h63, 7'h67, 7'h6f, 7'h73, 7'h7f
  };

  logic                  clk;
  logic                  arst_n;
  logic                  in_valid;
  logic                  in_ready;
  logic [31:0]           in_instr;
  logic [XLEN-1:0]       in_pc;
  logic                  out_valid;
  logic                  out_ready;
  rv_decode_pkg::id_ex_t out_payload;
  logic                  wb_en;
  logic [4:0]            wb_rd;
  logic [XLEN-1:0]       wb_data;

  // Driver modes
  logic            ready_random = 1'b0;
  logic            ready_hold   = 1'b0;
  logic            wb_random    = 1'b0;
  int              errors       = 0;
  int              tests_failed = 0;
  int              test_start   = 0;
  int              cycles       = 0;
  int              accepted     = 0;
  int              delivered    = 0;
  logic [XLEN-1:0] next_pc;

  clk_gen u_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  decode_stage UUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_instr    (in_instr),
    .in_pc       (in_pc),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_payload (out_payload),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  // ==========================================================
  // Background drivers, counters and timeout
  // ==========================================================
  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (ready_hold) begin
        out_ready = 1'b0;
      end else begin
        out_ready = ready_random ? (($urandom % 4) != 0) : 1'b1;
      end
    end
  end

  // Writes aimed mostly at x0..x3 so reads collide often
  initial begin
    wb_en   = 1'b0;
    wb_rd   = 5'd0;
    wb_data = '0;
    forever begin
      @(posedge clk);
      #1;
      wb_en   = wb_random && ($urandom % 2 == 1);
      wb_rd   = ($urandom % 2 == 1) ? 5'($urandom % 4) : 5'($urandom);
      wb_data = XLEN'($urandom);
    end
  end

  // Transfers completing at the next rising edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (in_valid && in_ready) begin
        accepted++;
      end
      if (out_valid && out_ready) begin
        delivered++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // ==========================================================
  // Helpers
  // ==========================================================
  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] want);
    assert (got === want) else begin
      $display("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
      errors++;
    end
  endtask

  function automatic int failures();
    return errors + int'(UUT.u_properties.fail_count);
  endfunction

  task automatic report(input string name);
    int n;
    n = failures() - test_start;
    if (n == 0) begin
      $display("Test %-14s ok", name);
    end else begin
      $display("Test %-14s FAILED with %0d errors", name, n);
      tests_failed++;
    end
    test_start = failures();
  endtask

  // Hold valid until the stage takes the item
  task automatic send(input logic [31:0] instr);
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    in_instr = instr;
    in_pc    = next_pc;
    next_pc  = next_pc + 4;
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  // Flag order csr ecall ebreak mret sret sfence muldiv word atomic fp
  task automatic classify(input logic [31:0] instr, input logic [9:0] want_flags,
                          input rv_decode_pkg::alu_op_e want_alu, input logic want_write,
                          input logic want_illegal);
    rv_decode_pkg::dec_flags_t f;
    send(instr);
    f = out_payload.flags;
    check_value($sformatf("flags of %h", instr), 64'({f.is_csr, f.is_ecall, f.is_ebreak,
                f.is_mret, f.is_sret, f.is_sfence_vma, f.is_mul_div, f.is_word_op,
                f.is_atomic, f.is_fp}), 64'(want_flags));
    check_value($sformatf("alu_op of %h", instr), 64'(out_payload.ctrl.alu_op),
                64'(want_alu));
    check_value($sformatf("reg_write of %h", instr), 64'(out_payload.ctrl.reg_write),
                64'(want_write));
    check_value($sformatf("illegal of %h", instr), 64'(out_payload.ctrl.illegal),
                64'(want_illegal));
  endtask

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    logic [31:0] instr;
    void'($urandom(32'hdbca_c43c));
    in_valid = 1'b0;
    in_instr = 32'h00000013;
    in_pc    = '0;
    next_pc  = 'h1000;

    @(negedge clk);
    while (!arst_n) begin
      check_value("out_valid in reset", 64'(out_valid), 64'd0);
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    check_value("out_valid after reset", 64'(out_valid), 64'd0);
    report("reset");

    classify(FIXED[0], 10'b0100000000, rv_decode_pkg::add, 1'b0, 1'b0);
    classify(FIXED[1], 10'b0010000000, rv_decode_pkg::add, 1'b0, 1'b0);
    classify(FIXED[2], 10'b0001000000, rv_decode_pkg::add, 1'b0, 1'b0);
    classify(FIXED[3], 10'b0000100000, rv_decode_pkg::add, 1'b0, 1'b0);
    classify(FIXED[4], 10'b0000010000, rv_decode_pkg::add, 1'b0, 1'b0);
    classify(FIXED[5], 10'b1000000000, rv_decode_pkg::add, 1'b1, 1'b0);
    check_value("csr_addr of CSRRW", 64'(out_payload.flags.csr_addr), 64'h300);
    classify(FIXED[6], 10'b0000001000, rv_decode_pkg::mul_div, 1'b1, 1'b0);
    // W op is legal only on RV64
    classify(FIXED[7], 10'b0000001100, rv_decode_pkg::mul_div, 1'b1, (XLEN == 32));
    classify(FIXED[8], 10'b0000000010, rv_decode_pkg::add, 1'b1, 1'b0);
    check_value("aq of AMO", 64'(out_payload.flags.aq), 64'd1);
    classify(FIXED[9], 10'b0000000001, rv_decode_pkg::add, 1'b0, 1'b0);
    check_value("fp_fmt of FMADD.D", 64'(out_payload.flags.fp_fmt), 64'd1);
    classify(FIXED[10], 10'b0000000000, rv_decode_pkg::sub, 1'b1, 1'b0);
    classify(FIXED[11], 10'b0000000000, rv_decode_pkg::sra, 1'b1, 1'b0);
    classify(FIXED[12], 10'b0000000000, rv_decode_pkg::add, 1'b0, 1'b1);
    report("classification");

    // Random encodings with a fixed one every eighth item
    ready_random = 1'b1;
    wb_random    = 1'b1;
    for (int i = 0; i < RAND_ITEMS; i++) begin
      if (i % 8 == 7) begin
        instr = FIXED[$urandom % 13];
      end else begin
        instr      = $urandom;
        instr[6:0] = OPCODES[$urandom % 20];
        if ($urandom % 2 == 1) begin
          instr[19:15] = 5'($urandom % 4);
          instr[24:20] = 5'($urandom % 4);
        end
      end
      send(instr);
    end
    report("random");

    // Drain so the stalled item is the only one in flight
    ready_random = 1'b0;
    wb_random    = 1'b0;
    @(negedge clk);
    while (out_valid) begin
      @(negedge clk);
    end
    ready_hold = 1'b1;
    send(32'h00a00093);
    repeat (4) @(posedge clk);
    #1;
    check_value("out_valid under stall", 64'(out_valid), 64'd1);
    // Release and replace the item in the cycle it leaves
    @(negedge clk);
    ready_hold = 1'b0;
    send(FIXED[10]);
    @(negedge clk);
    while (out_valid) begin
      @(negedge clk);
    end
    check_value("delivered count", 64'(delivered), 64'(accepted));
    report("back-pressure");

    $display("Summary: %0d tests failed, %0d checks failed, %0d accepted, %0d delivered",
             tests_failed, failures(), accepted, delivered);
    if (failures() == 0 && tests_failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+common
common/rv_decode_pkg.sv
rtl/decoder/decoder.sv
rtl/decoder/control_unit.sv
rtl/regfile.sv
rtl/decode_stage.sv
verification/clk_gen.sv
verification/decode_stage_properties.sv
verification/tb_decode_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the decode stage testbench with Verilator.
# Exit status is nonzero when the run reports failure.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
rm -f "$BUILD_LOG" "$SIM_LOG"

# Keep running past assertion errors so the testbench prints its verdict
verilator --binary --assert -j 0 --top-module tb_decode_stage -f files.f -o sim_tb \
  > "$BUILD_LOG" 2>&1 \
  && ./obj_dir/sim_tb +verilator+error+limit+10000 > "$SIM_LOG" 2>&1 \
  || { cat "$BUILD_LOG" "$SIM_LOG" 2>/dev/null; echo "Build or run aborted"; exit 1; }

cat "$SIM_LOG"
grep -q "Simulation failed" "$SIM_LOG" && { echo "Result: FAIL"; exit 1; }
grep -q "Simulation passed" "$SIM_LOG" || { echo "Result: no verdict in log"; exit 1; }
echo "Result: PASS"
